// File: list.f
+incdir+logic
logic/dram_addr_pkg.sv
logic/dram_line_pkg.sv
logic/dram_request_router.sv
logic/dram_line_bank.sv
logic/dram_return_merge.sv
logic/dram_banked_top.sv
sim/dram_banked_tb.sv

// File: logic/dram_addr_pkg.sv
`include "dram_settings.svh"

package dram_addr_pkg;

  // ==============================
  // address split
  // ==============================
  // low bits pick the bank, the rest pick the row in that bank.
  localparam int BANK_BITS = $clog2(`DRAM_BANKS);
  localparam int ROW_BITS  = `LINE_ADDR_BITS - BANK_BITS;
  localparam int ROWS      = 2 ** ROW_BITS; // lines per bank.

  // full line address as seen on the ports.
  typedef logic [`LINE_ADDR_BITS-1:0] line_addr_t;

  // bank index.
  typedef logic [BANK_BITS-1:0] bank_sel_t;

  // line index inside one bank.
  typedef logic [ROW_BITS-1:0] row_addr_t;

endpackage

// File: logic/dram_banked_top.sv
`timescale 1ns/1ns
`include "dram_settings.svh"

module dram_banked_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      rd_req,
  input  logic                      wr_req,
  input  dram_addr_pkg::line_addr_t addr,
  input  dram_line_pkg::line_t      wdata,
  output logic                      busy,
  output logic                      rvalid,
  output dram_addr_pkg::line_addr_t raddr,
  output dram_line_pkg::line_t      rdata
);

  // router side.
  logic [`DRAM_BANKS-1:0]   bank_busy;
  logic [`DRAM_BANKS-1:0]   bank_rd_en;
  logic [`DRAM_BANKS-1:0]   bank_wr_en;
  dram_addr_pkg::row_addr_t row;

  // merge side.
  logic [`DRAM_BANKS-1:0]   bank_ready;
  dram_addr_pkg::row_addr_t bank_rrow [`DRAM_BANKS];
  dram_line_pkg::line_t     bank_rdata [`DRAM_BANKS];

  // ==============================
  // request routing
  // ==============================
  dram_request_router u_router (
    .clk        (clk),
    .reset      (reset),
    .addr       (addr),
    .rd_req     (rd_req),
    .wr_req     (wr_req),
    .bank_busy  (bank_busy),
    .bank_rd_en (bank_rd_en),
    .bank_wr_en (bank_wr_en),
    .row        (row),
    .busy       (busy)
  );

  // ==============================
  // banks
  // ==============================
  // row and wdata fan out to every bank, the enables pick one.
  for (genvar g = 0; g < `DRAM_BANKS; g++) begin : g_bank
    dram_line_bank u_bank (
      .clk   (clk),
      .reset (reset),
      .rd_en (bank_rd_en[g]),
      .wr_en (bank_wr_en[g]),
      .row   (row),
      .wdata (wdata),
      .busy  (bank_busy[g]),
      .ready (bank_ready[g]),
      .rrow  (bank_rrow[g]),
      .rdata (bank_rdata[g])
    );
  end

  // ==============================
  // response
  // ==============================
  dram_return_merge u_merge (
    .clk        (clk),
    .reset      (reset),
    .bank_ready (bank_ready),
    .bank_rrow  (bank_rrow),
    .bank_rdata (bank_rdata),
    .rvalid     (rvalid),
    .raddr      (raddr),
    .rdata      (rdata)
  );

endmodule

// File: logic/dram_line_bank.sv
`timescale 1ns/1ns
`include "dram_settings.svh"

module dram_line_bank (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      rd_en,
  input  logic                      wr_en,
  input  dram_addr_pkg::row_addr_t  row,
  input  dram_line_pkg::line_t      wdata,
  output logic                      busy,
  output logic                      ready,
  output dram_addr_pkg::row_addr_t  rrow,
  output dram_line_pkg::line_t      rdata
);

  // counter needs at least one bit even for latency 1.
  localparam int CNT_BITS = (`DRAM_LATENCY > 1) ? $clog2(`DRAM_LATENCY) : 1;
  localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(`DRAM_LATENCY - 1);

  // ==============================
  // storage
  // ==============================
  // row by byte, as a byte-addressed DRAM would hold it.
  dram_line_pkg::byte_t mem [0:dram_addr_pkg::ROWS-1][0:`LINE_BYTES-1];

  logic [CNT_BITS-1:0] count;
  logic                done;

  assign done = busy && (count == CNT_LAST);

  // whole line in one edge.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < `LINE_BYTES; b++) begin
        mem[row][b] <= wdata[b];
      end
    end
  end

  // ==============================
  // latency counter
  // ==============================
  // busy rises on acceptance, drops on the edge that raises ready.
  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      count <= '0;
      ready <= 1'b0;
    end else if (rd_en) begin
      busy  <= 1'b1; // start of a new read.
      count <= '0;
      ready <= 1'b0;
    end else if (done) begin
      busy  <= 1'b0;
      count <= '0;
      ready <= 1'b1; // one-cycle pulse.
    end else begin
      if (busy) begin
        count <= count + 1'b1;
      end
      ready <= 1'b0;
    end
  end

  // row held for the whole pending read.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rrow <= row;
    end
  end

  // ==============================
  // read return
  // ==============================
  // data is fetched on the last edge, so earlier writes are seen.
  always_ff @(posedge clk) begin
    if (done) begin
      for (int b = 0; b < `LINE_BYTES; b++) begin
        rdata[b] <= mem[rrow][b];
      end
    end
  end

  // the router must hold off both strobes while a read is pending.
  a_no_access_while_busy: assert property (
    @(posedge clk) disable iff (reset) busy |-> !(rd_en || wr_en)
  );

endmodule

// File: logic/dram_line_pkg.sv
`include "dram_settings.svh"

package dram_line_pkg;

  // ==============================
  // line payload
  // ==============================

  typedef logic [7:0] byte_t;

  // byte 0 sits in bits 7:0, byte 15 in bits 127:120.
  typedef byte_t [`LINE_BYTES-1:0] line_t;

  // total line width, 128 bits for 16-byte lines.
  localparam int LINE_BITS = $bits(line_t);

endpackage

// File: logic/dram_request_router.sv
`timescale 1ns/1ns
`include "dram_settings.svh"

module dram_request_router (
  input  logic                       clk,
  input  logic                       reset,
  input  dram_addr_pkg::line_addr_t  addr,
  input  logic                       rd_req,
  input  logic                       wr_req,
  input  logic [`DRAM_BANKS-1:0]     bank_busy,
  output logic [`DRAM_BANKS-1:0]     bank_rd_en,
  output logic [`DRAM_BANKS-1:0]     bank_wr_en,
  output dram_addr_pkg::row_addr_t   row,
  output logic                       busy
);

  dram_addr_pkg::bank_sel_t bank_sel;
  logic                     accept_rd;
  logic                     accept_wr;

  // ==============================
  // decode
  // ==============================
  assign bank_sel = addr[dram_addr_pkg::BANK_BITS-1:0];
  assign row      = addr[`LINE_ADDR_BITS-1:dram_addr_pkg::BANK_BITS];

  // busy follows the addressed bank only.
  assign busy = bank_busy[bank_sel];

  // a refused request is dropped.
  assign accept_rd = rd_req && !busy;
  assign accept_wr = wr_req && !busy;

  always_comb begin
    bank_rd_en = '0;
    bank_wr_en = '0;
    bank_rd_en[bank_sel] = accept_rd;
    bank_wr_en[bank_sel] = accept_wr;
  end

  // ==============================
  // checks
  // ==============================
  // caller keeps the two strobes apart.
  a_strobes_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(rd_req && wr_req)
  );

  // one enable of either kind per edge at most.
  a_one_bank_enabled: assert property (
    @(posedge clk) disable iff (reset) $onehot0({bank_rd_en, bank_wr_en})
  );

endmodule

// File: logic/dram_return_merge.sv
`timescale 1ns/1ns
`include "dram_settings.svh"

module dram_return_merge (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`DRAM_BANKS-1:0]    bank_ready,
  input  dram_addr_pkg::row_addr_t  bank_rrow [`DRAM_BANKS],
  input  dram_line_pkg::line_t      bank_rdata [`DRAM_BANKS],
  output logic                      rvalid,
  output dram_addr_pkg::line_addr_t raddr,
  output dram_line_pkg::line_t      rdata
);

  dram_addr_pkg::bank_sel_t sel;
  logic                     hit;

  // ==============================
  // pick the finishing bank
  // ==============================
  // at most one bank is ready, so a plain scan is enough.
  always_comb begin
    sel = '0;
    for (int i = 0; i < `DRAM_BANKS; i++) begin
      if (bank_ready[i]) begin
        sel = dram_addr_pkg::bank_sel_t'(i);
      end
    end
  end

  assign hit = |bank_ready;

  // ==============================
  // response register
  // ==============================
  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= hit;
    end
  end

  // row goes back on top, bank index in the low bits.
  always_ff @(posedge clk) begin
    if (hit) begin
      raddr <= {bank_rrow[sel], sel};
      rdata <= bank_rdata[sel];
    end
  end

  // fixed latency and one acceptance per edge keep this one-hot.
  a_ready_onehot: assert property (
    @(posedge clk) disable iff (reset) $onehot0(bank_ready)
  );

endmodule

// File: logic/dram_settings.svh
`ifndef DRAM_SETTINGS_SVH
`define DRAM_SETTINGS_SVH

// line geometry.
`define LINE_BYTES      16

// bank count, power of two only.
`define DRAM_BANKS      4

// full line address width, 1024 lines.
`define LINE_ADDR_BITS  10

// edges from read acceptance to bank ready.
`define DRAM_LATENCY    4

// extra watchdog cycles beyond the vector count.
`define WATCHDOG_MARGIN 50

`endif

// File: run_sim.sh
#!/bin/sh
# compile and run the banked DRAM testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module dram_banked_tb \
  -Mdir obj_dir \
  -f list.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vdram_banked_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: sim/dram_banked_tb.sv
`timescale 1ns/1ns
`include "dram_settings.svh"

module dram_banked_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 3;
  localparam int READ_LATENCY = 5; // accept edge to rvalid, top level.
  localparam int CMP_BITS     = dram_line_pkg::LINE_BITS; // widest compared value.

  // vector operation codes.
  localparam int OP_IDLE  = 0;
  localparam int OP_READ  = 1;
  localparam int OP_WRITE = 2;
  localparam int OP_RESET = 3;

  logic                      clk = 1'b0;
  logic                      reset;
  logic                      rd_req;
  logic                      wr_req;
  dram_addr_pkg::line_addr_t addr;
  dram_line_pkg::line_t      wdata;
  logic                      busy;
  logic                      rvalid;
  dram_addr_pkg::line_addr_t raddr;
  dram_line_pkg::line_t      rdata;

  int                        vec_test [$];
  int                        vec_op [$];
  dram_addr_pkg::line_addr_t vec_addr [$];
  dram_line_pkg::line_t      vec_data [$];
  logic                      vectors_loaded = 1'b0;

  // ==============================
  // reference model state
  // ==============================
  dram_line_pkg::line_t      ref_mem [dram_addr_pkg::line_addr_t];
  int                        busy_until [`DRAM_BANKS]; // first edge with the bank free.
  dram_addr_pkg::line_addr_t exp_addr [$];
  dram_line_pkg::line_t      exp_data [$];
  int                        exp_due [$];

  int edge_cnt    = 0;
  int cur_test    = 0;
  int test_errors = 0;
  int tests_run   = 0;
  int checks      = 0;
  int errors      = 0;

  dram_banked_top UUT (
    .clk    (clk),
    .reset  (reset),
    .rd_req (rd_req),
    .wr_req (wr_req),
    .addr   (addr),
    .wdata  (wdata),
    .busy   (busy),
    .rvalid (rvalid),
    .raddr  (raddr),
    .rdata  (rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  function automatic string test_name(input int num);
    case (num)
      1: return "write_readback";
      2: return "overlapped_reads";
      3: return "busy_refusal";
      4: return "refused_write";
      5: return "read_after_write";
      6: return "reset";
      default: return "unnamed";
    endcase
  endfunction

  task automatic compare(input string what, input logic [CMP_BITS-1:0] expected,
                         input logic [CMP_BITS-1:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("Error: test %0d %s, %s: expected %0h, actual %0h",
               cur_test, test_name(cur_test), what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic load_vectors(output logic ok);
    int    fd;
    int    t;
    int    op;
    string line;
    dram_addr_pkg::line_addr_t a;
    dram_line_pkg::line_t      d;
    ok = 1'b0;
    fd = $fopen("sim/dram_vectors.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while ($fgets(line, fd) != 0) begin
        // header and blank lines do not scan as four fields.
        if ($sscanf(line, "%d %h %h %h", t, op, a, d) == 4) begin
          vec_test.push_back(t);
          vec_op.push_back(op);
          vec_addr.push_back(a);
          vec_data.push_back(d);
        end
      end
      $fclose(fd);
    end
  endtask

  // ==============================
  // response side
  // ==============================
  task automatic collect_response();
    if (rvalid) begin
      if (exp_due.size() == 0) begin
        $display("Error: test %0d %s: response for line %0h came with no read outstanding",
                 cur_test, test_name(cur_test), raddr);
        errors++;
        test_errors++;
      end else begin
        compare("raddr", CMP_BITS'(exp_addr[0]), CMP_BITS'(raddr));
        compare("rdata", exp_data[0], rdata);
        compare("response edge", CMP_BITS'(exp_due[0]), CMP_BITS'(edge_cnt));
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        void'(exp_due.pop_front());
      end
    end else if (exp_due.size() != 0 && exp_due[0] <= edge_cnt) begin
      $display("Error: test %0d %s: no response for line %0h by edge %0d",
               cur_test, test_name(cur_test), exp_addr[0], exp_due[0]);
      errors++;
      test_errors++;
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
      void'(exp_due.pop_front());
    end
  endtask

  // one clock cycle: check outputs, drive inputs, predict the next edge.
  task automatic step_cycle(input int op, input dram_addr_pkg::line_addr_t a,
                            input dram_line_pkg::line_t d);
    dram_addr_pkg::bank_sel_t bank;
    logic                     exp_busy;
    @(negedge clk);
    collect_response();
    reset  = (op == OP_RESET);
    rd_req = (op == OP_READ);
    wr_req = (op == OP_WRITE);
    addr   = a;
    wdata  = d;
    #1; // let the busy decode settle.
    bank     = dram_addr_pkg::bank_sel_t'(a % `DRAM_BANKS);
    exp_busy = (edge_cnt < busy_until[bank]);
    compare("busy", CMP_BITS'(exp_busy), CMP_BITS'(busy));
    if (op == OP_RESET) begin
      // pending reads are lost at the reset edge.
      foreach (busy_until[b]) begin
        busy_until[b] = 0;
      end
      exp_addr.delete();
      exp_data.delete();
      exp_due.delete();
    end else if (op == OP_WRITE && !exp_busy) begin
      ref_mem[a] = d;
    end else if (op == OP_READ && !exp_busy) begin
      exp_addr.push_back(a);
      exp_data.push_back(ref_mem[a]);
      exp_due.push_back(edge_cnt + 1 + READ_LATENCY);
      busy_until[bank] = edge_cnt + 1 + `DRAM_LATENCY;
    end
  endtask

  task automatic drain_reads();
    while (exp_due.size() != 0) begin
      step_cycle(OP_IDLE, '0, '0);
    end
  endtask

  task automatic report_test();
    if (test_errors == 0) begin
      $display("test %0d %s: ok", cur_test, test_name(cur_test));
    end else begin
      $display("test %0d %s: %0d error(s)", cur_test, test_name(cur_test), test_errors);
    end
    tests_run++;
    test_errors = 0;
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin : main
    logic ok;
    reset  = 1'b1;
    rd_req = 1'b0;
    wr_req = 1'b0;
    addr   = '0;
    wdata  = '0;
    foreach (busy_until[b]) begin
      busy_until[b] = 0;
    end
    load_vectors(ok);
    vectors_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    if (!ok) begin
      $display("Error: vector file sim/dram_vectors.txt could not be opened");
      errors++;
    end else begin
      for (int i = 0; i < vec_op.size(); i++) begin
        if (vec_test[i] != cur_test) begin
          if (cur_test != 0) begin
            drain_reads(); // finish the old test first.
            report_test();
          end
          cur_test = vec_test[i];
        end
        step_cycle(vec_op[i], vec_addr[i], vec_data[i]);
      end
      drain_reads();
      if (cur_test != 0) begin
        report_test();
      end
    end
    $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // bounded by the vector count plus slack for drains.
  initial begin : watchdog
    wait (vectors_loaded);
    #((vec_op.size() + `WATCHDOG_MARGIN) * CLK_PERIOD);
    $display("Error: watchdog timeout, the run did not finish within %0d cycles",
             vec_op.size() + `WATCHDOG_MARGIN);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: sim/dram_vectors.txt
# test(dec)  op(0 idle, 1 read, 2 write, 3 reset)  line address(hex)  line data(hex, byte 0 rightmost)
# one line per clock cycle.
1 2 010 00112233445566778899aabbccddeeff
1 2 021 0f1e2d3c4b5a69788796a5b4c3d2e1f0
1 2 032 deadbeef0123456789abcdeffedcba98
1 2 3c3 55aa55aa33cc33cc0ff00ff0a5a5a5a5
1 1 010 0
1 0 000 0
1 1 021 0
1 0 000 0
1 1 032 0
1 0 000 0
1 1 3c3 0
2 1 010 0
2 1 021 0
2 1 032 0
2 1 3c3 0
3 2 014 11112222333344445555666677778888
3 1 010 0
3 1 014 0
3 1 014 0
3 1 014 0
3 1 014 0
3 1 014 0
4 2 025 0102030405060708090a0b0c0d0e0f10
4 1 021 0
4 2 025 f0e0d0c0b0a090807060504030201000
4 0 000 0
4 0 000 0
4 0 000 0
4 1 025 0
5 2 136 cafef00dcafef00dcafef00dcafef00d
5 1 136 0
5 2 137 8badf00d8badf00d8badf00d8badf00d
5 1 137 0
6 2 208 7766554433221100ffeeddccbbaa9988
6 2 1fd 13579bdf02468ace13579bdf02468ace
6 1 208 0
6 3 000 0
6 3 000 0
6 3 000 0
6 1 208 0
6 1 1fd 0
